/* build.f */
+incdir+design
design/riscv_decode_pkg.sv
design/alu_op_decoder.sv
design/lsu_op_decoder.sv
design/flow_op_decoder.sv
design/decoder_riscv.sv
tests/tb_clock_gen.sv
tests/decoder_riscv_properties.sv
tests/tb_decoder_riscv.sv

/* design/alu_op_decoder.sv */
module alu_op_decoder import riscv_decode_pkg::*; (
  input  instr_u       instr_i,
  output logic         hit_o,
  output decode_ctrl_t ctrl_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       shift_imm;

  // only SUB and SRA take the alternate funct7
  function automatic logic funct7_ok(input logic [2:0] f3, input logic [6:0] f7);
    return (f7 == 7'b0000000) ||
           ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101)));
  endfunction

  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLTS;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e branch_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return ALU_EQ;
      3'b001:  return ALU_NE;
      3'b100:  return ALU_LTS;
      3'b101:  return ALU_GES;
      3'b110:  return ALU_LTU;
      default: return ALU_GEU;
    endcase
  endfunction

  assign funct3    = instr_i.i_fmt.funct3;
  assign funct7    = instr_i.r_fmt.funct7;   // upper imm12 for OP-IMM
  assign shift_imm = (funct3[1:0] == 2'b01);  // slli, srli, srai

  always_comb begin
    hit_o  = 1'b0;
    ctrl_o = CTRL_ILLEGAL;
    case (instr_i.r_fmt.opcode)
      OPC_OP: begin
        hit_o = 1'b1;
        if (funct7_ok(funct3, funct7)) begin
          ctrl_o        = CTRL_NOP;
          ctrl_o.gpr_we = 1'b1;
          ctrl_o.alu_op = arith_op(funct3, funct7[5]);
        end
      end
      OPC_OP_IMM: begin
        hit_o = 1'b1;
        // plain immediates carry no funct7
        if (!shift_imm || funct7_ok(funct3, funct7)) begin
          ctrl_o        = CTRL_NOP;
          ctrl_o.b_sel  = OP_B_IMM_I;
          ctrl_o.gpr_we = 1'b1;
          ctrl_o.alu_op = arith_op(funct3, shift_imm & funct7[5]);
        end
      end
      OPC_BRANCH: begin
        hit_o = 1'b1;
        if (funct3[2:1] != 2'b01) begin  // 010 and 011 unused
          ctrl_o        = CTRL_NOP;
          ctrl_o.branch = 1'b1;
          ctrl_o.alu_op = branch_op(funct3);
        end
      end
      default: ;
    endcase
  end

endmodule

/* design/decoder_riscv.sv */
module decoder_riscv import riscv_decode_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         instr_valid_i,
  input  instr_u       instr_i,
  output logic         ctrl_valid_o,
  output decode_ctrl_t ctrl_o
);

  instr_u             instr_q;
  logic               valid_q;
  logic         [2:0] hit;
  decode_ctrl_t [2:0] claim;

  // the bundle is a pure function of instr_q, so it holds until the next strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      instr_q <= INSTR_FENCE;  // idle word decodes to the inactive bundle
    end else begin
      valid_q <= instr_valid_i;
      if (instr_valid_i) begin
        instr_q <= instr_i;
      end
    end
  end

  alu_op_decoder u_alu_dec (
    .instr_i (instr_q),
    .hit_o   (hit[0]),
    .ctrl_o  (claim[0])
  );

  lsu_op_decoder u_lsu_dec (
    .instr_i (instr_q),
    .hit_o   (hit[1]),
    .ctrl_o  (claim[1])
  );

  flow_op_decoder u_flow_dec (
    .instr_i (instr_q),
    .hit_o   (hit[2]),
    .ctrl_o  (claim[2])
  );

  // at most one class claims a word
  always_comb begin
    ctrl_o = CTRL_ILLEGAL;  // system, unknown opcode, low bits != 11
    for (int i = 0; i < 3; i++) begin
      if (hit[i]) begin
        ctrl_o = claim[i];
      end
    end
  end

  assign ctrl_valid_o = valid_q;

endmodule

/* design/flow_op_decoder.sv */
module flow_op_decoder import riscv_decode_pkg::*; (
  input  instr_u       instr_i,
  output logic         hit_o,
  output decode_ctrl_t ctrl_o
);

  logic f3_zero;

  assign f3_zero = (instr_i.i_fmt.funct3 == 3'b000);

  always_comb begin
    hit_o  = 1'b0;
    ctrl_o = CTRL_ILLEGAL;
    case (instr_i.i_fmt.opcode)
      OPC_LUI: begin
        hit_o         = 1'b1;
        ctrl_o        = CTRL_NOP;
        ctrl_o.a_sel  = OP_A_ZERO;  // 0 + upper immediate
        ctrl_o.b_sel  = OP_B_IMM_U;
        ctrl_o.gpr_we = 1'b1;
      end
      OPC_AUIPC: begin
        hit_o         = 1'b1;
        ctrl_o        = CTRL_NOP;
        ctrl_o.a_sel  = OP_A_CURR_PC;
        ctrl_o.b_sel  = OP_B_IMM_U;
        ctrl_o.gpr_we = 1'b1;
      end
      OPC_JAL: begin
        hit_o         = 1'b1;
        ctrl_o        = CTRL_NOP;
        ctrl_o.a_sel  = OP_A_CURR_PC;  // rd gets pc + 4
        ctrl_o.b_sel  = OP_B_INCR;
        ctrl_o.gpr_we = 1'b1;
        ctrl_o.jal    = 1'b1;
      end
      OPC_JALR: begin
        hit_o = 1'b1;
        if (f3_zero) begin
          ctrl_o        = CTRL_NOP;
          ctrl_o.a_sel  = OP_A_CURR_PC;
          ctrl_o.b_sel  = OP_B_INCR;
          ctrl_o.gpr_we = 1'b1;
          ctrl_o.jalr   = 1'b1;
        end
      end
      OPC_MISC_MEM: begin
        hit_o = 1'b1;
        if (f3_zero) begin
          ctrl_o = CTRL_NOP;  // fence, nothing to order here
        end
      end
      default: ;
    endcase
  end

endmodule

/* design/lsu_op_decoder.sv */
module lsu_op_decoder import riscv_decode_pkg::*; (
  input  instr_u       instr_i,
  output logic         hit_o,
  output decode_ctrl_t ctrl_o
);

  logic [2:0] funct3;
  logic       load_ok;
  logic       store_ok;

  assign funct3   = instr_i.i_fmt.funct3;
  assign load_ok  = funct3 inside {MEM_BYTE, MEM_HALF, MEM_WORD, MEM_BYTE_U, MEM_HALF_U};
  assign store_ok = funct3 inside {MEM_BYTE, MEM_HALF, MEM_WORD};  // no unsigned stores

  always_comb begin
    hit_o  = 1'b0;
    ctrl_o = CTRL_ILLEGAL;
    case (instr_i.i_fmt.opcode)
      OPC_LOAD: begin
        hit_o = 1'b1;
        if (load_ok) begin
          ctrl_o          = CTRL_NOP;
          ctrl_o.b_sel    = OP_B_IMM_I;  // rs1 + offset
          ctrl_o.alu_op   = ALU_ADD;
          ctrl_o.mem_req  = 1'b1;
          ctrl_o.mem_size = mem_size_e'(funct3);
          ctrl_o.gpr_we   = 1'b1;
          ctrl_o.wb_sel   = WB_LSU_DATA;
        end
      end
      OPC_STORE: begin
        hit_o = 1'b1;
        if (store_ok) begin
          ctrl_o          = CTRL_NOP;
          ctrl_o.b_sel    = OP_B_IMM_S;  // split offset
          ctrl_o.alu_op   = ALU_ADD;
          ctrl_o.mem_req  = 1'b1;
          ctrl_o.mem_we   = 1'b1;
          ctrl_o.mem_size = mem_size_e'(funct3);
        end
      end
      default: ;
    endcase
  end

endmodule

/* design/riscv_decode_cfg.svh */
`ifndef RISCV_DECODE_CFG_SVH
`define RISCV_DECODE_CFG_SVH

// instruction word
`define XLEN        32

// major opcode field, low two bits included
`define OPCODE_W    7

// ALU operation code
`define ALU_OP_W    5

// load/store access size, bit 2 marks unsigned loads
`define MEM_SIZE_W  3

// operand A select
`define A_SEL_W     2

// operand B select
`define B_SEL_W     3

// write-back source select
`define WB_SEL_W    2

`endif

/* design/riscv_decode_pkg.sv */
`include "riscv_decode_cfg.svh"

package riscv_decode_pkg;

  typedef enum logic [`OPCODE_W-1:0] {
    OPC_LOAD     = 7'b00_000_11,
    OPC_MISC_MEM = 7'b00_011_11,
    OPC_OP_IMM   = 7'b00_100_11,
    OPC_AUIPC    = 7'b00_101_11,
    OPC_STORE    = 7'b01_000_11,
    OPC_OP       = 7'b01_100_11,
    OPC_LUI      = 7'b01_101_11,
    OPC_BRANCH   = 7'b11_000_11,
    OPC_JALR     = 7'b11_001_11,
    OPC_JAL      = 7'b11_011_11,
    OPC_SYSTEM   = 7'b11_100_11  // not decoded, falls to illegal
  } opcode_e;

  typedef enum logic [`ALU_OP_W-1:0] {
    ALU_ADD  = 5'b00000,
    ALU_SUB  = 5'b01000,
    ALU_XOR  = 5'b00100,
    ALU_OR   = 5'b00110,
    ALU_AND  = 5'b00111,
    ALU_SLL  = 5'b00001,
    ALU_SRL  = 5'b00101,
    ALU_SRA  = 5'b01101,
    ALU_SLTS = 5'b00010,
    ALU_SLTU = 5'b00011,
    ALU_EQ   = 5'b11000,  // compares have bit 4 set
    ALU_NE   = 5'b11001,
    ALU_LTS  = 5'b11100,
    ALU_GES  = 5'b11101,
    ALU_LTU  = 5'b11110,
    ALU_GEU  = 5'b11111
  } alu_op_e;

  typedef enum logic [`A_SEL_W-1:0] {
    OP_A_RS1     = 2'd0,
    OP_A_CURR_PC = 2'd1,
    OP_A_ZERO    = 2'd2
  } op_a_sel_e;

  typedef enum logic [`B_SEL_W-1:0] {
    OP_B_RS2   = 3'd0,
    OP_B_IMM_I = 3'd1,
    OP_B_IMM_U = 3'd2,
    OP_B_IMM_S = 3'd3,
    OP_B_INCR  = 3'd4  // link address, pc + 4
  } op_b_sel_e;

  typedef enum logic [`WB_SEL_W-1:0] {
    WB_EX_RESULT = 2'd0,
    WB_LSU_DATA  = 2'd1
  } wb_sel_e;

  // encoded as the load/store funct3
  typedef enum logic [`MEM_SIZE_W-1:0] {
    MEM_BYTE   = 3'd0,
    MEM_HALF   = 3'd1,
    MEM_WORD   = 3'd2,
    MEM_BYTE_U = 3'd4,
    MEM_HALF_U = 3'd5
  } mem_size_e;

  typedef struct packed {
    logic [6:0]  funct7;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  // shift-immediates read imm12[11:5] as funct7
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

  typedef struct packed {
    op_a_sel_e a_sel;
    op_b_sel_e b_sel;
    alu_op_e   alu_op;
    logic      mem_req;
    logic      mem_we;
    mem_size_e mem_size;
    logic      gpr_we;
    wb_sel_e   wb_sel;
    logic      branch;
    logic      jal;
    logic      jalr;
    logic      illegal;
  } decode_ctrl_t;

  localparam decode_ctrl_t CTRL_NOP = '{
    a_sel: OP_A_RS1, b_sel: OP_B_RS2, alu_op: ALU_ADD,
    mem_req: 1'b0, mem_we: 1'b0, mem_size: MEM_BYTE,
    gpr_we: 1'b0, wb_sel: WB_EX_RESULT,
    branch: 1'b0, jal: 1'b0, jalr: 1'b0, illegal: 1'b0
  };

  localparam decode_ctrl_t CTRL_ILLEGAL = '{
    a_sel: OP_A_RS1, b_sel: OP_B_RS2, alu_op: ALU_ADD,
    mem_req: 1'b0, mem_we: 1'b0, mem_size: MEM_BYTE,
    gpr_we: 1'b0, wb_sel: WB_EX_RESULT,
    branch: 1'b0, jal: 1'b0, jalr: 1'b0, illegal: 1'b1
  };

  // fence with all fields zero
  localparam instr_u INSTR_FENCE = {{(`XLEN-`OPCODE_W){1'b0}}, OPC_MISC_MEM};

endpackage

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then judge the log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_decoder_riscv \
  -f build.f -o tb_decoder_riscv || { echo "build failed"; exit 1; }
./obj_dir/tb_decoder_riscv +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tests/decoder_riscv_properties.sv */
module decoder_riscv_properties import riscv_decode_pkg::*; (
  input logic         clk_i,
  input logic         arst_n_i,
  input logic         instr_valid_i,
  input logic         ctrl_valid_i,
  input decode_ctrl_t ctrl_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;  // read by the testbench top
  logic        any_flag;

  assign any_flag = ctrl_i.gpr_we | ctrl_i.mem_req | ctrl_i.mem_we |
                    ctrl_i.branch | ctrl_i.jal | ctrl_i.jalr;

  valid_follows_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ctrl_valid_i == $past(instr_valid_i))
  else begin
    $error("ctrl_valid_o is not instr_valid_i delayed by one cycle");
    fail_count++;
  end

  // low during reset and on the first edge after release
  valid_low_in_reset: assert property (@(posedge clk_i)
    (!arst_n_i || $rose(arst_n_i)) |-> !ctrl_valid_i)
  else begin
    $error("ctrl_valid_o high during or right after reset");
    fail_count++;
  end

  illegal_is_inert: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ctrl_valid_i && ctrl_i.illegal) |-> !any_flag)
  else begin
    $error("illegal bundle has an active enable");
    fail_count++;
  end

  flow_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({ctrl_i.branch, ctrl_i.jal, ctrl_i.jalr}))
  else begin
    $error("more than one of branch, jal, jalr set");
    fail_count++;
  end

  mem_flags_consistent: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (!ctrl_i.mem_we || ctrl_i.mem_req) && !((ctrl_i.branch || ctrl_i.mem_we) && ctrl_i.gpr_we))
  else begin
    $error("memory write without request, or register write on branch or store");
    fail_count++;
  end

endmodule

bind decoder_riscv decoder_riscv_properties u_props (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .instr_valid_i (instr_valid_i),
  .ctrl_valid_i  (ctrl_valid_o),
  .ctrl_i        (ctrl_o)
);

/* tests/tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2) clk_o = ~clk_o;  // 50% duty

endmodule

/* tests/tb_decoder_riscv.sv */
`include "riscv_decode_cfg.svh"

module tb_decoder_riscv import riscv_decode_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_DIRECTED  = 66;
  localparam int N_RANDOM    = 300;
  localparam int PERIOD_NS   = 100;
  localparam int WATCHDOG_NS = (N_DIRECTED + N_RANDOM) * 3 * PERIOD_NS;

  logic         clk;
  logic         arst_n;
  logic         instr_valid;
  instr_u       instr;
  logic         ctrl_valid;
  decode_ctrl_t ctrl;

  decode_ctrl_t exp_q[$];
  string        name_q[$];
  bit           chk_q[$];
  decode_ctrl_t cur_exp;
  string        cur_name;
  bit           cur_chk;
  int           errors = 0;
  int unsigned  assert_errors;

  alu_op_e arith_ops[8]  = '{ALU_ADD, ALU_SLL, ALU_SLTS, ALU_SLTU,
                             ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
  alu_op_e branch_ops[8] = '{ALU_EQ, ALU_NE, ALU_ADD, ALU_ADD,  // 2, 3 unused
                             ALU_LTS, ALU_GES, ALU_LTU, ALU_GEU};
  mem_size_e access_sizes[8] = '{MEM_BYTE, MEM_HALF, MEM_WORD, MEM_BYTE,  // 3, 6, 7 unused
                                 MEM_BYTE_U, MEM_HALF_U, MEM_BYTE, MEM_BYTE};

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS)) u_clk (.clk_o(clk));

  decoder_riscv dut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .ctrl_valid_o  (ctrl_valid),
    .ctrl_o        (ctrl)
  );

  function automatic decode_ctrl_t bundle(input op_a_sel_e a, input op_b_sel_e b,
                                          input alu_op_e op, input logic gpr_we);
    decode_ctrl_t c;
    c        = '0;
    c.a_sel  = a;
    c.b_sel  = b;
    c.alu_op = op;
    c.gpr_we = gpr_we;
    return c;
  endfunction

  function automatic decode_ctrl_t illegal_bundle();
    decode_ctrl_t c;
    c         = '0;  // RS1, RS2, ADD, BYTE, EX_RESULT all encode as 0
    c.illegal = 1'b1;
    return c;
  endfunction

  task automatic send(input string name, input logic [`XLEN-1:0] word,
                      input decode_ctrl_t exp, input bit chk);
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = word;
    name_q.push_back(name);
    exp_q.push_back(exp);
    chk_q.push_back(chk);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      instr_valid = 1'b0;
    end
  endtask

  task automatic run_alu();
    decode_ctrl_t e;
    logic [2:0]   f3;
    logic         alt;
    logic         shift;
    for (int i = 0; i < 16; i++) begin
      f3    = 3'(i >> 1);
      alt   = i[0];
      shift = (f3 == 3'd1) || (f3 == 3'd5);
      e = illegal_bundle();
      if (!alt || f3 == 3'd0 || f3 == 3'd5) begin
        e = bundle(OP_A_RS1, OP_B_RS2, arith_ops[f3], 1'b1);
        if (alt) e.alu_op = (f3 == 3'd0) ? ALU_SUB : ALU_SRA;
      end
      send($sformatf("op f3=%0d alt=%0b", f3, alt),
           {alt ? 7'b0100000 : 7'b0000000, 5'd3, 5'd2, f3, 5'd1, OPC_OP}, e, 1'b1);
      e = illegal_bundle();
      if (!shift || !alt || f3 == 3'd5) begin  // plain immediates ignore the upper bits
        e = bundle(OP_A_RS1, OP_B_IMM_I, arith_ops[f3], 1'b1);
        if (shift && alt) e.alu_op = ALU_SRA;
      end
      send($sformatf("op-imm f3=%0d alt=%0b", f3, alt),
           {alt ? 7'b0100000 : 7'b0000000, 5'd7, 5'd2, f3, 5'd1, OPC_OP_IMM}, e, 1'b1);
      e = illegal_bundle();
      if (f3 != 3'd2 && f3 != 3'd3 && !alt) begin
        e        = bundle(OP_A_RS1, OP_B_RS2, branch_ops[f3], 1'b0);
        e.branch = 1'b1;
      end
      if (!alt) send($sformatf("branch f3=%0d", f3),
                     {7'd0, 5'd3, 5'd2, f3, 5'd1, OPC_BRANCH}, e, 1'b1);
    end
  endtask

  task automatic run_memory();
    decode_ctrl_t e;
    logic [2:0]   f3;
    for (int i = 0; i < 8; i++) begin
      f3 = 3'(i);
      e  = illegal_bundle();
      if (f3 != 3'd3 && f3 < 3'd6) begin
        e          = bundle(OP_A_RS1, OP_B_IMM_I, ALU_ADD, 1'b1);
        e.mem_req  = 1'b1;
        e.mem_size = access_sizes[f3];
        e.wb_sel   = WB_LSU_DATA;
      end
      send($sformatf("load f3=%0d", f3), {12'h010, 5'd2, f3, 5'd1, OPC_LOAD}, e, 1'b1);
      e = illegal_bundle();
      if (f3 <= 3'd2) begin
        e          = bundle(OP_A_RS1, OP_B_IMM_S, ALU_ADD, 1'b0);
        e.mem_req  = 1'b1;
        e.mem_we   = 1'b1;
        e.mem_size = access_sizes[f3];
      end
      send($sformatf("store f3=%0d", f3), {7'd0, 5'd3, 5'd2, f3, 5'd4, OPC_STORE}, e, 1'b1);
    end
  endtask

  task automatic run_flow();
    decode_ctrl_t e;
    send("lui", {20'h12345, 5'd1, OPC_LUI}, bundle(OP_A_ZERO, OP_B_IMM_U, ALU_ADD, 1'b1), 1'b1);
    send("auipc", {20'h00abc, 5'd1, OPC_AUIPC},
         bundle(OP_A_CURR_PC, OP_B_IMM_U, ALU_ADD, 1'b1), 1'b1);
    e     = bundle(OP_A_CURR_PC, OP_B_INCR, ALU_ADD, 1'b1);
    e.jal = 1'b1;
    send("jal", {20'h00100, 5'd1, OPC_JAL}, e, 1'b1);
    e      = bundle(OP_A_CURR_PC, OP_B_INCR, ALU_ADD, 1'b1);
    e.jalr = 1'b1;
    send("jalr f3=0", {12'h004, 5'd2, 3'd0, 5'd1, OPC_JALR}, e, 1'b1);
    send("jalr f3=1", {12'h004, 5'd2, 3'd1, 5'd1, OPC_JALR}, illegal_bundle(), 1'b1);
    send("fence", {12'h0ff, 5'd0, 3'd0, 5'd0, OPC_MISC_MEM},
         bundle(OP_A_RS1, OP_B_RS2, ALU_ADD, 1'b0), 1'b1);
    send("fence f3=1", {12'h000, 5'd0, 3'd1, 5'd0, OPC_MISC_MEM}, illegal_bundle(), 1'b1);
    send("ecall", {25'd0, OPC_SYSTEM}, illegal_bundle(), 1'b1);
    send("opcode 0", 32'h0000_0000, illegal_bundle(), 1'b1);
  endtask

  task automatic run_random();
    logic [`XLEN-1:0] word;
    for (int n = 0; n < N_RANDOM; n++) begin
      word = $urandom();
      if ($urandom_range(1) == 1) word[1:0] = 2'b11;  // half of them look like rv32
      idle(int'($urandom_range(2)));
      send("random", word, '0, 1'b0);
    end
  endtask

  always @(negedge clk) begin
    if (ctrl_valid) begin
      if (exp_q.size() == 0) begin
        $display("unexpected result: ctrl_valid_o high with nothing outstanding");
        errors++;
      end else begin
        cur_name = name_q.pop_front();
        cur_exp  = exp_q.pop_front();
        cur_chk  = chk_q.pop_front();
        if (cur_chk && ctrl !== cur_exp) begin
          $display("[ERROR] %s: expected %h, actual %h", cur_name, cur_exp, ctrl);
          errors++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: no result after %0d ns, %0d errors so far", WATCHDOG_NS, errors);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    void'($urandom(12647));
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    run_alu();
    run_memory();
    run_flow();
    send("low bits 01", {25'd0, 7'b0110001}, illegal_bundle(), 1'b1);
    run_random();
    idle(1);
    while (exp_q.size() != 0) @(negedge clk);
    idle(2);  // last edges for the bound checks
    assert_errors = dut.u_props.fail_count;
    $display("errors: %0d table, %0d assertion", errors, assert_errors);
    if (errors == 0 && assert_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
